// File: Makefile
# Verilator flow for the KMAC application front end

VERILATOR ?= verilator
TOP       ?= tb_kmac_app
FLIST     ?= kmac_app.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

# The binary exits non-zero on $$fatal, so make fails with it
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/tb_kmac_app.sv
// Testbench for the KMAC application front end
// Core model with random back-pressure, reference stream and beat checker

`timescale 1ns/1ps

module tb_kmac_app;

  localparam int N       = kmac_app_cfg_pkg::NumAppIntf;
  localparam int W       = kmac_app_cfg_pkg::MsgWidth;
  localparam int Timeout = 200;

  logic clk_i, rst_ni;
  logic [N-1:0] app_valid_i, app_last_i, app_ready_o, app_done_o, app_error_o;
  logic [N-1:0][W-1:0] app_data_i;
  logic [N-1:0][7:0] app_strb_i;
  logic [N-1:0][255:0] app_digest_o;
  logic sw_valid_i, sw_ready_o, absorbed_o, absorbed_i, entropy_ready_i;
  logic [W-1:0] sw_data_i, sw_mask_i, kmac_data_o, kmac_mask_o;
  kmac_ctrl_pkg::kmac_cmd_e sw_cmd_i, cmd_o;
  logic kmac_valid_o, kmac_ready_i, kmac_en_o, reg_kmac_en_i;
  logic [1599:0] keccak_state_i;
  kmac_app_cfg_pkg::sha3_mode_e sha3_mode_o, reg_sha3_mode_i;
  kmac_app_cfg_pkg::keccak_strength_e keccak_strength_o, reg_keccak_strength_i;
  logic app_active_o, err_valid_o;
  kmac_ctrl_pkg::err_code_e err_code_o;
  logic [23:0] err_info_o;

  // Expected core stream and observed events
  logic [W-1:0] exp_data_q[$];
  logic [W-1:0] exp_mask_q[$];
  int done_order[$];
  int n_start, n_proc, n_done, pend;
  logic [W-1:0] msg_data [N][8];
  logic [7:0]   msg_strb [N][8];

  kmac_app UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [255:0] got, input logic [255:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0h exp %0h", $time, name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  // Expected core beat where idx equal to nbeats gives the right-encoded length of 256
  function automatic logic [2*W-1:0] ref_beat(input int port, input int idx, input int nbeats);
    logic [W-1:0] d;
    logic [W-1:0] m;
    if (idx == nbeats) begin
      d = 64'h0000_0000_0002_0001;
      m = 64'h0000_0000_00ff_ffff;
    end else begin
      d = msg_data[port][idx];
      for (int b = 0; b < W; b++) begin
        m[b] = msg_strb[port][idx][b/8];
      end
    end
    return {d, m};
  endfunction

  // Random message for a port with a partially strobed last beat
  // Port 0 is KMAC and gets the output-length beat
  task automatic load_msg(input int port, input int nbeats, input bit to_core);
    logic [2*W-1:0] beat;
    int total;
    total = nbeats + ((port == 0) ? 1 : 0);
    for (int i = 0; i < nbeats; i++) begin
      msg_data[port][i] = {$urandom, $urandom};
      msg_strb[port][i] = (i == nbeats - 1) ? (8'($urandom) | 8'h01) : 8'hff;
    end
    for (int i = 0; to_core && i < total; i++) begin
      beat = ref_beat(port, i, nbeats);
      exp_data_q.push_back(beat[2*W-1:W]);
      exp_mask_q.push_back(beat[W-1:0]);
    end
  endtask

  // Drain mode must take a beat every cycle after the first
  task automatic send_msg(input int port, input int nbeats, input bit drain);
    int cnt;
    bit rdy;
    for (int i = 0; i < nbeats; i++) begin
      app_valid_i[port] = 1'b1;
      app_data_i[port]  = msg_data[port][i];
      app_strb_i[port]  = msg_strb[port][i];
      app_last_i[port]  = (i == nbeats - 1);
      cnt = 0;
      do begin
        #5;
        rdy = app_ready_o[port];
        @(negedge clk_i);
        cnt++;
        if (cnt > Timeout) fail_run("timeout waiting for port ready");
      end while (!rdy);
      if (drain && i > 0) check_val("beat_wait_cycles", 256'(cnt), 256'd1);
    end
    app_valid_i[port] = 1'b0;
    app_last_i[port]  = 1'b0;
  endtask

  task automatic wait_done(input int port, input bit exp_err);
    int cnt;
    bit seen;
    cnt  = 0;
    seen = 1'b0;
    while (!seen) begin
      #5;
      if (app_done_o[port]) begin
        seen = 1'b1;
        check_val("app_error_o", 256'(app_error_o[port]), 256'(exp_err));
        check_val("app_digest_o", app_digest_o[port],
                  exp_err ? 256'd0 : keccak_state_i[255:0]);
      end
      @(negedge clk_i);
      cnt++;
      if (cnt > Timeout) fail_run("timeout waiting for port done");
    end
  endtask

  // Port 0 is KMAC L256, port 1 cSHAKE L128 and port 2 SHA3 L512
  task automatic check_cfg(input int port);
    check_val("kmac_en_o", 256'(kmac_en_o), 256'(port == 0));
    check_val("sha3_mode_o", 256'(sha3_mode_o),
              256'((port == 2) ? kmac_app_cfg_pkg::Sha3 : kmac_app_cfg_pkg::CShake));
    check_val("keccak_strength_o", 256'(keccak_strength_o),
              256'((port == 0) ? kmac_app_cfg_pkg::L256 :
                   (port == 1) ? kmac_app_cfg_pkg::L128 : kmac_app_cfg_pkg::L512));
  endtask

  task automatic run_hash(input int port, input int nbeats);
    send_msg(port, nbeats, 1'b0);
    check_cfg(port);
    wait_done(port, 1'b0);
  endtask

  task automatic check_cmds(input int num);
    check_val("start_count", 256'(n_start), 256'(num));
    check_val("process_count", 256'(n_proc), 256'(num));
    check_val("done_count", 256'(n_done), 256'(num));
    check_val("pending_beats", 256'(exp_data_q.size()), 256'd0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Core model
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    kmac_ready_i   = 1'b0;
    absorbed_i     = 1'b0;
    keccak_state_i = '0;
    pend           = 0;
    forever begin
      @(negedge clk_i);
      kmac_ready_i = ($urandom % 4) != 0;
      absorbed_i   = 1'b0;
      if (pend > 0) begin
        pend--;
        if (pend == 0) begin
          absorbed_i = 1'b1;
          for (int k = 0; k < 50; k++) keccak_state_i[32*k+:32] = $urandom;
        end
      end
      #5;
      // Absorb finishes 2 to 10 cycles after process
      if (cmd_o == kmac_ctrl_pkg::CmdProcess) pend = 2 + int'($urandom % 9);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [N-1:0] act;
    n_start = 0;
    n_proc  = 0;
    n_done  = 0;
    forever begin
      @(negedge clk_i);
      #5;
      if (rst_ni) begin
        if (kmac_valid_o && kmac_ready_i) begin
          if (exp_data_q.size() == 0) begin
            fail_run("core accepted a beat that was not expected");
          end else begin
            check_val("kmac_data_o", 256'(kmac_data_o), 256'(exp_data_q.pop_front()));
            check_val("kmac_mask_o", 256'(kmac_mask_o), 256'(exp_mask_q.pop_front()));
          end
        end
        if (cmd_o == kmac_ctrl_pkg::CmdStart) n_start++;
        if (cmd_o == kmac_ctrl_pkg::CmdProcess) n_proc++;
        if (cmd_o == kmac_ctrl_pkg::CmdDone) n_done++;
        // Responses must reach one port at most
        for (int i = 0; i < N; i++) begin
          act[i] = app_ready_o[i] | app_done_o[i] | (app_digest_o[i] != '0);
          if (app_digest_o[i] != '0 && !app_done_o[i]) fail_run("digest leaked without done");
          if (app_done_o[i]) done_order.push_back(i);
        end
        if ($countones(act) > 1) fail_run("response seen on more than one port");
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int cnt;
    bit seen;
    void'($urandom(90));
    rst_ni = 1'b0;
    app_valid_i = '0;
    app_last_i  = '0;
    app_data_i  = '0;
    app_strb_i  = '0;
    sw_valid_i  = 1'b0;
    sw_data_i   = '0;
    sw_mask_i   = '0;
    sw_cmd_i    = kmac_ctrl_pkg::CmdNone;
    entropy_ready_i       = 1'b1;
    reg_kmac_en_i         = 1'b0;
    reg_sha3_mode_i       = kmac_app_cfg_pkg::Sha3;
    reg_keccak_strength_i = kmac_app_cfg_pkg::L256;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_val("cmd_o", 256'(cmd_o), 256'(kmac_ctrl_pkg::CmdNone));
    check_val("reset_outputs", 256'({app_ready_o, app_done_o, app_error_o, kmac_valid_o,
              err_valid_o, absorbed_o, app_active_o, kmac_en_o}), 256'd0);
    check_val("sha3_mode_o", 256'(sha3_mode_o), 256'(kmac_app_cfg_pkg::Sha3));
    check_val("keccak_strength_o", 256'(keccak_strength_o), 256'(kmac_app_cfg_pkg::L256));
    rst_ni = 1'b1;

    // KMAC port with output-length beat
    load_msg(0, 4, 1'b1);
    run_hash(0, 4);
    check_cmds(1);

    // cSHAKE and SHA3 ports
    load_msg(1, 3, 1'b1);
    run_hash(1, 3);
    load_msg(2, 5, 1'b1);
    run_hash(2, 5);
    check_cmds(3);

    // Ports 0 and 2 request together and the lower index goes first
    done_order.delete();
    load_msg(0, 2, 1'b1);
    load_msg(2, 3, 1'b1);
    fork
      run_hash(0, 2);
      run_hash(2, 3);
    join
    check_val("done_count", 256'(done_order.size()), 256'd2);
    check_val("first_done_port", 256'(done_order[0]), 256'd0);
    check_val("second_done_port", 256'(done_order[1]), 256'd2);
    check_cmds(5);

    // KMAC without entropy is drained and rejected
    entropy_ready_i = 1'b0;
    load_msg(0, 3, 1'b0);
    send_msg(0, 3, 1'b1);
    wait_done(0, 1'b1);
    entropy_ready_i = 1'b1;
    check_cmds(5);

    // Software pass-through
    sw_cmd_i = kmac_ctrl_pkg::CmdStart;
    #5 check_val("cmd_o", 256'(cmd_o), 256'(kmac_ctrl_pkg::CmdStart));
    @(negedge clk_i);
    sw_cmd_i = kmac_ctrl_pkg::CmdNone;
    for (int i = 0; i < 2; i++) begin
      sw_valid_i = 1'b1;
      sw_data_i  = {$urandom, $urandom};
      sw_mask_i  = {$urandom, $urandom};
      exp_data_q.push_back(sw_data_i);
      exp_mask_q.push_back(sw_mask_i);
      cnt = 0;
      do begin
        #5;
        seen = sw_ready_o;
        @(negedge clk_i);
        cnt++;
        if (cnt > Timeout) fail_run("timeout waiting for software ready");
      end while (!seen);
    end
    sw_valid_i = 1'b0;
    sw_cmd_i   = kmac_ctrl_pkg::CmdProcess;
    #5 check_val("cmd_o", 256'(cmd_o), 256'(kmac_ctrl_pkg::CmdProcess));
    @(negedge clk_i);
    sw_cmd_i = kmac_ctrl_pkg::CmdNone;
    cnt = 0;
    do begin
      #5;
      check_val("absorbed_o", 256'(absorbed_o), 256'(absorbed_i));
      seen = absorbed_o;
      @(negedge clk_i);
      cnt++;
      if (cnt > Timeout) fail_run("timeout waiting for absorbed");
    end while (!seen);
    sw_cmd_i = kmac_ctrl_pkg::CmdDone;
    #5 check_val("cmd_o", 256'(cmd_o), 256'(kmac_ctrl_pkg::CmdDone));
    @(negedge clk_i);
    sw_cmd_i = kmac_ctrl_pkg::CmdNone;
    check_cmds(6);

    // Software data while a port owns the bus
    load_msg(1, 4, 1'b1);
    fork
      run_hash(1, 4);
      begin
        cnt = 0;
        while (!app_active_o) begin
          @(negedge clk_i);
          cnt++;
          if (cnt > Timeout) fail_run("timeout waiting for application active");
        end
        @(negedge clk_i);
        sw_valid_i = 1'b1;
        #5;
        check_val("err_valid_o", 256'(err_valid_o), 256'd1);
        check_val("err_code_o", 256'(err_code_o), 256'(kmac_ctrl_pkg::ErrSwPushedMsgFifo));
        // Info field carries the select that owned the bus
        check_val("err_info_o", 256'(err_info_o), 256'(kmac_ctrl_pkg::SelApp));
        @(negedge clk_i);
        sw_valid_i = 1'b0;
      end
    join
    check_cmds(7);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: kmac_app.f
rtl/kmac_app_cfg_pkg.sv
rtl/kmac_ctrl_pkg.sv
rtl/app_arbiter.sv
rtl/app_ctrl_fsm.sv
rtl/msg_mux.sv
rtl/app_resp_demux.sv
rtl/kmac_app.sv
dv/tb_kmac_app.sv

// File: rtl/app_arbiter.sv
// Application port arbiter
// Fixed priority, lowest requesting port index wins

`timescale 1ns/1ps

module app_arbiter (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [kmac_app_cfg_pkg::NumAppIntf-1:0] req_i,
  output logic                                  valid_o,
  output logic [kmac_app_cfg_pkg::AppIdxW-1:0]    idx_o
);

  // Any request pending
  assign valid_o = |req_i;

  // Walk from the top so the lowest index is written last
  always_comb begin
    idx_o = '0;
    for (int i = kmac_app_cfg_pkg::NumAppIntf - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        idx_o = kmac_app_cfg_pkg::AppIdxW'(i);
      end
    end
  end

endmodule

// File: rtl/app_ctrl_fsm.sv
// Application control FSM
// Grants a port, applies its configuration and sequences the core commands,
// rejects KMAC service without entropy and passes software commands through

`timescale 1ns/1ps

module app_ctrl_fsm (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      arb_valid_i,
  input  logic [kmac_app_cfg_pkg::AppIdxW-1:0]      arb_idx_i,
  input  logic                                      sel_last_valid_i,
  input  logic                                      app_last_accepted_i,
  input  logic                                      outlen_accepted_i,
  input  kmac_ctrl_pkg::kmac_cmd_e                  sw_cmd_i,
  input  logic                                      absorbed_i,
  input  logic                                      entropy_ready_i,
  input  logic                                      reg_kmac_en_i,
  input  kmac_app_cfg_pkg::sha3_mode_e              reg_sha3_mode_i,
  input  kmac_app_cfg_pkg::keccak_strength_e        reg_keccak_strength_i,
  output logic [kmac_app_cfg_pkg::AppIdxW-1:0]      app_id_o,
  output kmac_ctrl_pkg::app_mux_sel_e               mux_sel_o,
  output kmac_ctrl_pkg::kmac_cmd_e                  cmd_o,
  output logic                                      absorbed_o,
  output logic                                      fsm_data_ready_o,
  output logic                                      digest_done_o,
  output logic                                      svc_err_o,
  output logic                                      app_active_o,
  output logic                                      kmac_en_o,
  output kmac_app_cfg_pkg::sha3_mode_e              sha3_mode_o,
  output kmac_app_cfg_pkg::keccak_strength_e        keccak_strength_o
);

  kmac_ctrl_pkg::app_st_e st_q, st_d;
  logic set_appid, clr_appid;
  logic rej_done_q, rej_done_d;
  logic svc_err_set;
  logic cur_is_kmac;

  kmac_app_cfg_pkg::app_cfg_t cur_cfg, arb_cfg;

  assign cur_cfg     = kmac_app_cfg_pkg::AppCfg[app_id_o];
  assign arb_cfg     = kmac_app_cfg_pkg::AppCfg[arb_idx_i];
  assign cur_is_kmac = (cur_cfg.mode == kmac_app_cfg_pkg::AppKMAC);

  ////////////////////////////////////////////////////////////////////////////
  // State and grant registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q       <= kmac_ctrl_pkg::StIdle;
      rej_done_q <= 1'b0;
    end else begin
      st_q       <= st_d;
      rej_done_q <= rej_done_d;
    end
  end

  // A new grant wins over the clear of the previous one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      app_id_o <= '0;
    end else if (set_appid) begin
      app_id_o <= arb_idx_i;
    end else if (clr_appid) begin
      app_id_o <= '0;
    end
  end

  // Rejection flag, held until done and error have gone out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      svc_err_o <= 1'b0;
    end else if (svc_err_set) begin
      svc_err_o <= 1'b1;
    end else if (rej_done_q) begin
      svc_err_o <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state and command generation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    st_d             = st_q;
    mux_sel_o        = kmac_ctrl_pkg::SelNone;
    cmd_o            = kmac_ctrl_pkg::CmdNone;
    absorbed_o       = 1'b0;
    set_appid        = 1'b0;
    clr_appid        = rej_done_q;
    svc_err_set      = 1'b0;
    fsm_data_ready_o = 1'b0;
    rej_done_d       = 1'b0;
    digest_done_o    = rej_done_q;

    unique case (st_q)
      kmac_ctrl_pkg::StIdle: begin
        // Ports take precedence over a software start
        if (arb_valid_i) begin
          st_d      = kmac_ctrl_pkg::StAppCfg;
          set_appid = 1'b1;
        end else if (sw_cmd_i == kmac_ctrl_pkg::CmdStart) begin
          st_d  = kmac_ctrl_pkg::StSw;
          cmd_o = kmac_ctrl_pkg::CmdStart;
        end
      end

      kmac_ctrl_pkg::StAppCfg: begin
        // KMAC needs entropy, otherwise drain the port and report
        if (cur_is_kmac && !entropy_ready_i) begin
          st_d        = kmac_ctrl_pkg::StErrRejected;
          svc_err_set = 1'b1;
        end else begin
          st_d  = kmac_ctrl_pkg::StAppMsg;
          cmd_o = kmac_ctrl_pkg::CmdStart;
        end
      end

      kmac_ctrl_pkg::StAppMsg: begin
        mux_sel_o = kmac_ctrl_pkg::SelApp;
        if (app_last_accepted_i) begin
          st_d = cur_is_kmac ? kmac_ctrl_pkg::StAppOutLen : kmac_ctrl_pkg::StAppProcess;
        end
      end

      kmac_ctrl_pkg::StAppOutLen: begin
        mux_sel_o = kmac_ctrl_pkg::SelOutLen;
        if (outlen_accepted_i) begin
          st_d = kmac_ctrl_pkg::StAppProcess;
        end
      end

      kmac_ctrl_pkg::StAppProcess: begin
        cmd_o = kmac_ctrl_pkg::CmdProcess;
        st_d  = kmac_ctrl_pkg::StAppWait;
      end

      kmac_ctrl_pkg::StAppWait: begin
        if (absorbed_i) begin
          cmd_o         = kmac_ctrl_pkg::CmdDone;
          digest_done_o = 1'b1;
          clr_appid     = 1'b1;
          st_d          = kmac_ctrl_pkg::StIdle;
        end
      end

      kmac_ctrl_pkg::StSw: begin
        mux_sel_o  = kmac_ctrl_pkg::SelSw;
        cmd_o      = sw_cmd_i;
        absorbed_o = absorbed_i;
        if (sw_cmd_i == kmac_ctrl_pkg::CmdDone) begin
          st_d = kmac_ctrl_pkg::StIdle;
        end
      end

      kmac_ctrl_pkg::StErrRejected: begin
        // Swallow beats, done and error follow the last one
        fsm_data_ready_o = 1'b1;
        if (sel_last_valid_i) begin
          rej_done_d = 1'b1;
          st_d       = kmac_ctrl_pkg::StIdle;
        end
      end

      default: st_d = kmac_ctrl_pkg::StIdle;
    endcase
  end

  assign app_active_o = st_q inside {kmac_ctrl_pkg::StAppCfg, kmac_ctrl_pkg::StAppMsg,
                                     kmac_ctrl_pkg::StAppOutLen, kmac_ctrl_pkg::StAppProcess,
                                     kmac_ctrl_pkg::StAppWait};

  ////////////////////////////////////////////////////////////////////////////
  // Configuration latch
  ////////////////////////////////////////////////////////////////////////////

  // Port table on grant, register values otherwise
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      kmac_en_o         <= 1'b0;
      sha3_mode_o       <= kmac_app_cfg_pkg::Sha3;
      keccak_strength_o <= kmac_app_cfg_pkg::L256;
    end else if (set_appid) begin
      kmac_en_o         <= (arb_cfg.mode == kmac_app_cfg_pkg::AppKMAC);
      sha3_mode_o       <= (arb_cfg.mode == kmac_app_cfg_pkg::AppSHA3) ?
                           kmac_app_cfg_pkg::Sha3 : kmac_app_cfg_pkg::CShake;
      keccak_strength_o <= arb_cfg.strength;
    end else if (clr_appid || st_q == kmac_ctrl_pkg::StIdle) begin
      kmac_en_o         <= reg_kmac_en_i;
      sha3_mode_o       <= reg_sha3_mode_i;
      keccak_strength_o <= reg_keccak_strength_i;
    end
  end

endmodule

// File: rtl/app_resp_demux.sv
// Response demux for the application ports
// Ready, done, digest and error go to the granted port, others see zero

`timescale 1ns/1ps

module app_resp_demux (
  input  logic [kmac_app_cfg_pkg::AppIdxW-1:0]  app_id_i,
  input  logic                                  app_data_ready_i,
  input  logic                                  fsm_data_ready_i,
  input  logic                                  digest_done_i,
  input  logic                                  svc_err_i,
  input  logic [kmac_app_cfg_pkg::StateW-1:0]   keccak_state_i,
  output logic [kmac_app_cfg_pkg::NumAppIntf-1:0] app_ready_o,
  output logic [kmac_app_cfg_pkg::NumAppIntf-1:0] app_done_o,
  output logic [kmac_app_cfg_pkg::NumAppIntf-1:0][kmac_app_cfg_pkg::AppDigestW-1:0] app_digest_o,
  output logic [kmac_app_cfg_pkg::NumAppIntf-1:0] app_error_o
);

  logic [kmac_app_cfg_pkg::AppDigestW-1:0] digest;

  // Digest only exists for the done cycle of a real hash
  assign digest = (digest_done_i && !svc_err_i) ?
                  keccak_state_i[kmac_app_cfg_pkg::AppDigestW-1:0] : '0;

  always_comb begin
    app_ready_o  = '0;
    app_done_o   = '0;
    app_digest_o = '0;
    app_error_o  = '0;
    for (int i = 0; i < kmac_app_cfg_pkg::NumAppIntf; i++) begin
      if (app_id_i == kmac_app_cfg_pkg::AppIdxW'(i)) begin
        app_ready_o[i]  = app_data_ready_i | fsm_data_ready_i;
        app_done_o[i]   = digest_done_i;
        app_digest_o[i] = digest;
        // Error is raised only alongside done
        app_error_o[i]  = digest_done_i & svc_err_i;
      end
    end
  end

endmodule

// File: rtl/kmac_app.sv
// KMAC application front end
// Arbitrates the hardware ports, sequences the core and routes responses

`timescale 1ns/1ps

module kmac_app (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Application ports
  input  logic [kmac_app_cfg_pkg::NumAppIntf-1:0] app_valid_i,
  input  logic [kmac_app_cfg_pkg::NumAppIntf-1:0][kmac_app_cfg_pkg::MsgWidth-1:0] app_data_i,
  input  logic [kmac_app_cfg_pkg::NumAppIntf-1:0][kmac_app_cfg_pkg::StrbWidth-1:0] app_strb_i,
  input  logic [kmac_app_cfg_pkg::NumAppIntf-1:0] app_last_i,
  output logic [kmac_app_cfg_pkg::NumAppIntf-1:0] app_ready_o,
  output logic [kmac_app_cfg_pkg::NumAppIntf-1:0] app_done_o,
  output logic [kmac_app_cfg_pkg::NumAppIntf-1:0][kmac_app_cfg_pkg::AppDigestW-1:0] app_digest_o,
  output logic [kmac_app_cfg_pkg::NumAppIntf-1:0] app_error_o,
  // Software port
  input  logic                                 sw_valid_i,
  input  logic [kmac_app_cfg_pkg::MsgWidth-1:0] sw_data_i,
  input  logic [kmac_app_cfg_pkg::MsgWidth-1:0] sw_mask_i,
  output logic                                 sw_ready_o,
  input  kmac_ctrl_pkg::kmac_cmd_e             sw_cmd_i,
  output logic                                 absorbed_o,
  // Core message bus and control
  output logic                                 kmac_valid_o,
  output logic [kmac_app_cfg_pkg::MsgWidth-1:0] kmac_data_o,
  output logic [kmac_app_cfg_pkg::MsgWidth-1:0] kmac_mask_o,
  input  logic                                 kmac_ready_i,
  output kmac_ctrl_pkg::kmac_cmd_e             cmd_o,
  input  logic                                 absorbed_i,
  input  logic [kmac_app_cfg_pkg::StateW-1:0]  keccak_state_i,
  output logic                                 kmac_en_o,
  output kmac_app_cfg_pkg::sha3_mode_e         sha3_mode_o,
  output kmac_app_cfg_pkg::keccak_strength_e   keccak_strength_o,
  // Register configuration and status
  input  logic                                 entropy_ready_i,
  input  logic                                 reg_kmac_en_i,
  input  kmac_app_cfg_pkg::sha3_mode_e         reg_sha3_mode_i,
  input  kmac_app_cfg_pkg::keccak_strength_e   reg_keccak_strength_i,
  output logic                                 app_active_o,
  output logic                                 err_valid_o,
  output kmac_ctrl_pkg::err_code_e             err_code_o,
  output logic [kmac_ctrl_pkg::ErrInfoW-1:0]   err_info_o
);

  logic                                 arb_valid;
  logic [kmac_app_cfg_pkg::AppIdxW-1:0] arb_idx;
  logic [kmac_app_cfg_pkg::AppIdxW-1:0] app_id;
  kmac_ctrl_pkg::app_mux_sel_e          mux_sel;
  logic sel_last_valid, app_last_accepted, outlen_accepted;
  logic app_data_ready, fsm_data_ready, digest_done, svc_err;

  app_arbiter u_arb (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (app_valid_i),
    .valid_o (arb_valid),
    .idx_o   (arb_idx)
  );

  app_ctrl_fsm u_fsm (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .arb_valid_i           (arb_valid),
    .arb_idx_i             (arb_idx),
    .sel_last_valid_i      (sel_last_valid),
    .app_last_accepted_i   (app_last_accepted),
    .outlen_accepted_i     (outlen_accepted),
    .sw_cmd_i              (sw_cmd_i),
    .absorbed_i            (absorbed_i),
    .entropy_ready_i       (entropy_ready_i),
    .reg_kmac_en_i         (reg_kmac_en_i),
    .reg_sha3_mode_i       (reg_sha3_mode_i),
    .reg_keccak_strength_i (reg_keccak_strength_i),
    .app_id_o              (app_id),
    .mux_sel_o             (mux_sel),
    .cmd_o                 (cmd_o),
    .absorbed_o            (absorbed_o),
    .fsm_data_ready_o      (fsm_data_ready),
    .digest_done_o         (digest_done),
    .svc_err_o             (svc_err),
    .app_active_o          (app_active_o),
    .kmac_en_o             (kmac_en_o),
    .sha3_mode_o           (sha3_mode_o),
    .keccak_strength_o     (keccak_strength_o)
  );

  msg_mux u_mux (
    .mux_sel_i           (mux_sel),
    .app_id_i            (app_id),
    .app_active_i        (app_active_o),
    .app_valid_i         (app_valid_i),
    .app_data_i          (app_data_i),
    .app_strb_i          (app_strb_i),
    .app_last_i          (app_last_i),
    .sw_valid_i          (sw_valid_i),
    .sw_data_i           (sw_data_i),
    .sw_mask_i           (sw_mask_i),
    .sw_cmd_i            (sw_cmd_i),
    .kmac_ready_i        (kmac_ready_i),
    .kmac_valid_o        (kmac_valid_o),
    .kmac_data_o         (kmac_data_o),
    .kmac_mask_o         (kmac_mask_o),
    .sw_ready_o          (sw_ready_o),
    .app_data_ready_o    (app_data_ready),
    .sel_last_valid_o    (sel_last_valid),
    .app_last_accepted_o (app_last_accepted),
    .outlen_accepted_o   (outlen_accepted),
    .err_valid_o         (err_valid_o),
    .err_code_o          (err_code_o),
    .err_info_o          (err_info_o)
  );

  app_resp_demux u_rsp (
    .app_id_i         (app_id),
    .app_data_ready_i (app_data_ready),
    .fsm_data_ready_i (fsm_data_ready),
    .digest_done_i    (digest_done),
    .svc_err_i        (svc_err),
    .keccak_state_i   (keccak_state_i),
    .app_ready_o      (app_ready_o),
    .app_done_o       (app_done_o),
    .app_digest_o     (app_digest_o),
    .app_error_o      (app_error_o)
  );

endmodule

// File: rtl/kmac_app_cfg_pkg.sv
// Application port configuration for the KMAC front end
// Bus widths, hashing modes and the fixed per-port configuration table

package kmac_app_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int NumAppIntf = 3;
  localparam int AppIdxW    = 2;
  localparam int MsgWidth   = 64;
  // One strobe bit per message byte
  localparam int StrbWidth  = MsgWidth / 8;
  localparam int AppDigestW = 256;
  localparam int StateW     = 1600;
  localparam int OutLenW    = 24;

  // right_encode(256), length byte sits in the MSB position
  localparam logic [OutLenW-1:0] EncodedOutLen     = 24'h02_0001;
  localparam logic [OutLenW-1:0] EncodedOutLenMask = 24'hFF_FFFF;

  ////////////////////////////////////////////////////////////////////////////
  // Modes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    AppKMAC   = 2'b00,
    AppCShake = 2'b01,
    AppSHA3   = 2'b10
  } app_mode_e;

  // Encoding as seen by the SHA3 core
  typedef enum logic [1:0] {
    Sha3   = 2'b00,
    CShake = 2'b11
  } sha3_mode_e;

  typedef enum logic [2:0] {
    L128 = 3'd0,
    L224 = 3'd1,
    L256 = 3'd2,
    L384 = 3'd3,
    L512 = 3'd4
  } keccak_strength_e;

  typedef struct packed {
    app_mode_e        mode;
    keccak_strength_e strength;
  } app_cfg_t;

  // Per-port configuration, indexed by port
  localparam app_cfg_t AppCfg [NumAppIntf] = '{
    '{mode: AppKMAC,   strength: L256},
    '{mode: AppCShake, strength: L128},
    '{mode: AppSHA3,   strength: L512}
  };

endpackage

// File: rtl/kmac_ctrl_pkg.sv
// Control definitions for the KMAC front end
// Core commands, message mux selects, FSM states and error codes

package kmac_ctrl_pkg;

  // Commands towards the hashing core
  typedef enum logic [2:0] {
    CmdNone    = 3'b000,
    CmdStart   = 3'b001,
    CmdProcess = 3'b010,
    CmdDone    = 3'b100
  } kmac_cmd_e;

  // Source of the core message bus
  typedef enum logic [1:0] {
    SelNone   = 2'b00,
    SelApp    = 2'b01,
    SelOutLen = 2'b10,
    SelSw     = 2'b11
  } app_mux_sel_e;

  typedef enum logic [3:0] {
    StIdle        = 4'd0,
    StAppCfg      = 4'd1,
    StAppMsg      = 4'd2,
    StAppOutLen   = 4'd3,
    StAppProcess  = 4'd4,
    StAppWait     = 4'd5,
    StSw          = 4'd6,
    StErrRejected = 4'd7
  } app_st_e;

  typedef enum logic [7:0] {
    ErrNone                   = 8'h00,
    ErrSwPushedMsgFifo        = 8'h02,
    ErrSwIssuedCmdInAppActive = 8'h03,
    ErrServiceRejected        = 8'h05
  } err_code_e;

  localparam int ErrInfoW = 24;

endpackage

// File: rtl/msg_mux.sv
// Message bus mux towards the hashing core
// Selects the granted port, the output-length beat or software, and flags
// software misuse of the bus

`timescale 1ns/1ps

module msg_mux (
  input  kmac_ctrl_pkg::app_mux_sel_e  mux_sel_i,
  input  logic [kmac_app_cfg_pkg::AppIdxW-1:0] app_id_i,
  input  logic                         app_active_i,
  input  logic [kmac_app_cfg_pkg::NumAppIntf-1:0] app_valid_i,
  input  logic [kmac_app_cfg_pkg::NumAppIntf-1:0][kmac_app_cfg_pkg::MsgWidth-1:0] app_data_i,
  input  logic [kmac_app_cfg_pkg::NumAppIntf-1:0][kmac_app_cfg_pkg::StrbWidth-1:0] app_strb_i,
  input  logic [kmac_app_cfg_pkg::NumAppIntf-1:0] app_last_i,
  input  logic                         sw_valid_i,
  input  logic [kmac_app_cfg_pkg::MsgWidth-1:0] sw_data_i,
  input  logic [kmac_app_cfg_pkg::MsgWidth-1:0] sw_mask_i,
  input  kmac_ctrl_pkg::kmac_cmd_e     sw_cmd_i,
  input  logic                         kmac_ready_i,
  output logic                         kmac_valid_o,
  output logic [kmac_app_cfg_pkg::MsgWidth-1:0] kmac_data_o,
  output logic [kmac_app_cfg_pkg::MsgWidth-1:0] kmac_mask_o,
  output logic                         sw_ready_o,
  output logic                         app_data_ready_o,
  output logic                         sel_last_valid_o,
  output logic                         app_last_accepted_o,
  output logic                         outlen_accepted_o,
  output logic                         err_valid_o,
  output kmac_ctrl_pkg::err_code_e     err_code_o,
  output logic [kmac_ctrl_pkg::ErrInfoW-1:0] err_info_o
);

  // Granted port shows its final beat, used in both message and drain modes
  assign sel_last_valid_o    = app_valid_i[app_id_i] & app_last_i[app_id_i];
  assign app_last_accepted_o = (mux_sel_i == kmac_ctrl_pkg::SelApp) & sel_last_valid_o &
                               kmac_ready_i;
  assign outlen_accepted_o   = (mux_sel_i == kmac_ctrl_pkg::SelOutLen) & kmac_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    kmac_valid_o     = 1'b0;
    kmac_data_o      = '0;
    kmac_mask_o      = '0;
    app_data_ready_o = 1'b0;
    // Software is never stalled outside its own mode
    sw_ready_o       = 1'b1;

    unique case (mux_sel_i)
      kmac_ctrl_pkg::SelApp: begin
        kmac_valid_o = app_valid_i[app_id_i];
        kmac_data_o  = app_data_i[app_id_i];
        // Byte strobe to bit mask
        for (int i = 0; i < kmac_app_cfg_pkg::StrbWidth; i++) begin
          kmac_mask_o[8*i+:8] = {8{app_strb_i[app_id_i][i]}};
        end
        app_data_ready_o = kmac_ready_i;
      end

      kmac_ctrl_pkg::SelOutLen: begin
        kmac_valid_o = 1'b1;
        kmac_data_o  = kmac_app_cfg_pkg::MsgWidth'(kmac_app_cfg_pkg::EncodedOutLen);
        kmac_mask_o  = kmac_app_cfg_pkg::MsgWidth'(kmac_app_cfg_pkg::EncodedOutLenMask);
      end

      kmac_ctrl_pkg::SelSw: begin
        kmac_valid_o = sw_valid_i;
        kmac_data_o  = sw_data_i;
        kmac_mask_o  = sw_mask_i;
        sw_ready_o   = kmac_ready_i;
      end

      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Misuse detection
  ////////////////////////////////////////////////////////////////////////////

  // Pushing data without owning the bus is reported first
  always_comb begin
    err_valid_o = 1'b0;
    err_code_o  = kmac_ctrl_pkg::ErrNone;
    err_info_o  = '0;
    if (mux_sel_i != kmac_ctrl_pkg::SelSw && sw_valid_i) begin
      err_valid_o = 1'b1;
      err_code_o  = kmac_ctrl_pkg::ErrSwPushedMsgFifo;
      err_info_o  = kmac_ctrl_pkg::ErrInfoW'(mux_sel_i);
    end else if (app_active_i && sw_cmd_i != kmac_ctrl_pkg::CmdNone) begin
      err_valid_o = 1'b1;
      err_code_o  = kmac_ctrl_pkg::ErrSwIssuedCmdInAppActive;
      err_info_o  = kmac_ctrl_pkg::ErrInfoW'(sw_cmd_i);
    end
  end

endmodule
